// ==== logic/rvPkg.sv ====
package rvPkg;

  typedef logic [63:0] xlen_t;
  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  regAddr_t;
  typedef logic [7:0]  byteMask_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opLui     = 7'b0110111,
    opAuipc   = 7'b0010111,
    opImm     = 7'b0010011,
    opReg     = 7'b0110011,
    opImm32   = 7'b0011011,
    opReg32   = 7'b0111011,
    opBranch  = 7'b1100011,
    opJal     = 7'b1101111,
    opJalr    = 7'b1100111,
    opLoad    = 7'b0000011,
    opStore   = 7'b0100011,
    opSystem  = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSll,
    aluSrl,
    aluSlt,
    aluAddw,
    aluSubw,
    aluPassB  // lui
  } aluOp_t;

  typedef enum logic [1:0] {opARs1, opAPc, opAZero} opASel_t;

  typedef enum logic {opBRs2, opBImm} opBSel_t;

  typedef enum logic [1:0] {wbAlu, wbLoad, wbPc4} wbSel_t;

  typedef enum logic [1:0] {memByte, memWord, memDouble} memSize_t;

  typedef enum logic [2:0] {
    brNone,
    brEq,
    brNe,
    brLt,
    brGe,
    brJal,
    brJalr
  } branchOp_t;

  localparam rvPkg::inst_t ebreakInst = 32'h00100073;

endpackage

// ==== logic/fetchUnit.sv ====
module fetchUnit #(
  parameter rvPkg::addr_t resetPc = '0,
  parameter int imemWords = 256
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  input  logic                         imemWe,
  input  logic [$clog2(imemWords)-1:0] imemAddr,
  input  rvPkg::inst_t                 imemData,
  input  logic                         takeBranch,
  input  rvPkg::addr_t                 target,
  input  logic                         isHalt,
  output rvPkg::addr_t                 pc,
  output rvPkg::inst_t                 inst,
  output logic                         step,
  output logic                         halted
);

  localparam int imemAw = $clog2(imemWords);

  rvPkg::inst_t imem [imemWords];
  rvPkg::addr_t nextPc;

  // one instruction retires per edge while this is high
  assign step = run && !halted && !rst;

  assign inst = imem[pc[2 +: imemAw]]; // word index, low bits dropped

  always_comb begin
    if (takeBranch) begin
      nextPc = target;
    end else begin
      nextPc = pc + 64'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= resetPc;
      halted <= 1'b0;
    end else if (step) begin
      if (isHalt) begin
        halted <= 1'b1; // pc parks on the ebreak
      end else begin
        pc <= nextPc;
      end
    end
  end

  // host load port, used while the core is stopped
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

endmodule

// ==== logic/instDecoder.sv ====
module instDecoder (
  input  rvPkg::inst_t      inst,
  input  logic              step,
  output rvPkg::regAddr_t   rs1Addr,
  output rvPkg::regAddr_t   rs2Addr,
  output rvPkg::regAddr_t   rdAddr,
  output rvPkg::xlen_t      imm,
  output rvPkg::aluOp_t     aluOp,
  output rvPkg::opASel_t    opASel,
  output rvPkg::opBSel_t    opBSel,
  output rvPkg::branchOp_t  branchOp,
  output logic              memRead,
  output logic              memWrite,
  output rvPkg::memSize_t   memSize,
  output logic              loadUnsigned,
  output rvPkg::wbSel_t     wbSel,
  output logic              rdWe,
  output logic              isHalt
);

  rvPkg::opcode_t opcode;
  logic [2:0]     funct3;
  logic           alt;  // funct7 bit 5
  rvPkg::xlen_t   immI, immS, immB, immU, immJ;
  logic           rdWeRaw;

  assign opcode  = rvPkg::opcode_t'(inst[6:0]);
  assign funct3  = inst[14:12];
  assign alt     = inst[30];
  assign rs1Addr = inst[19:15];
  assign rs2Addr = inst[24:20];
  assign rdAddr  = inst[11:7];

  assign immI = {{52{inst[31]}}, inst[31:20]};
  assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign isHalt = (inst == rvPkg::ebreakInst);
  assign rdWe   = rdWeRaw && step;

  always_comb begin
    // no-op unless an opcode below claims it
    imm          = immI;
    aluOp        = rvPkg::aluAdd;
    opASel       = rvPkg::opARs1;
    opBSel       = rvPkg::opBImm;
    branchOp     = rvPkg::brNone;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    memSize      = rvPkg::memDouble;
    loadUnsigned = 1'b0;
    wbSel        = rvPkg::wbAlu;
    rdWeRaw      = 1'b0;
    case (opcode)
      rvPkg::opLui: begin
        imm     = immU;
        opASel  = rvPkg::opAZero;
        aluOp   = rvPkg::aluPassB;
        rdWeRaw = 1'b1;
      end
      rvPkg::opAuipc: begin
        imm     = immU;
        opASel  = rvPkg::opAPc;
        rdWeRaw = 1'b1;
      end
      rvPkg::opImm, rvPkg::opReg: begin
        opBSel  = (opcode == rvPkg::opReg) ? rvPkg::opBRs2 : rvPkg::opBImm;
        rdWeRaw = 1'b1;
        case (funct3)
          3'b000: aluOp = (opcode == rvPkg::opReg && alt) ? rvPkg::aluSub : rvPkg::aluAdd;
          3'b001: aluOp = rvPkg::aluSll;
          3'b010: aluOp = rvPkg::aluSlt;
          3'b100: aluOp = rvPkg::aluXor;
          3'b101: begin
            aluOp   = rvPkg::aluSrl;
            rdWeRaw = !alt; // sra is not supported
          end
          3'b110: aluOp = rvPkg::aluOr;
          3'b111: aluOp = rvPkg::aluAnd;
          default: rdWeRaw = 1'b0;
        endcase
      end
      rvPkg::opImm32, rvPkg::opReg32: begin
        opBSel  = (opcode == rvPkg::opReg32) ? rvPkg::opBRs2 : rvPkg::opBImm;
        aluOp   = (opcode == rvPkg::opReg32 && alt) ? rvPkg::aluSubw : rvPkg::aluAddw;
        rdWeRaw = (funct3 == 3'b000); // addw, subw, addiw only
      end
      rvPkg::opBranch: begin
        imm    = immB;
        opBSel = rvPkg::opBRs2;
        case (funct3)
          3'b000:  branchOp = rvPkg::brEq;
          3'b001:  branchOp = rvPkg::brNe;
          3'b100:  branchOp = rvPkg::brLt;
          3'b101:  branchOp = rvPkg::brGe;
          default: branchOp = rvPkg::brNone;
        endcase
      end
      rvPkg::opJal: begin
        imm      = immJ;
        branchOp = rvPkg::brJal;
        wbSel    = rvPkg::wbPc4;
        rdWeRaw  = 1'b1;
      end
      rvPkg::opJalr: begin
        branchOp = rvPkg::brJalr;
        wbSel    = rvPkg::wbPc4;
        rdWeRaw  = 1'b1;
      end
      rvPkg::opLoad: begin
        wbSel        = rvPkg::wbLoad;
        loadUnsigned = (funct3 == 3'b100);
        memRead      = 1'b1;
        rdWeRaw      = 1'b1;
        case (funct3)
          3'b000, 3'b100: memSize = rvPkg::memByte;
          3'b010:         memSize = rvPkg::memWord;
          3'b011:         memSize = rvPkg::memDouble;
          default: begin
            memRead = 1'b0;
            rdWeRaw = 1'b0;
          end
        endcase
      end
      rvPkg::opStore: begin
        imm      = immS;
        memWrite = 1'b1;
        case (funct3)
          3'b000:  memSize = rvPkg::memByte;
          3'b010:  memSize = rvPkg::memWord;
          3'b011:  memSize = rvPkg::memDouble;
          default: memWrite = 1'b0;
        endcase
      end
      default: ; // opSystem only carries ebreak, handled by isHalt
    endcase
  end

endmodule

// ==== logic/registerFile.sv ====
module registerFile (
  input  logic            clk,
  input  logic            rst,
  input  rvPkg::regAddr_t rs1Addr,
  input  rvPkg::regAddr_t rs2Addr,
  input  rvPkg::regAddr_t rdAddr,
  input  rvPkg::xlen_t    rdData,
  input  logic            rdWe,
  output rvPkg::xlen_t    rs1Data,
  output rvPkg::xlen_t    rs2Data
);

  rvPkg::xlen_t regs [32];

  // x0 reads as zero whatever the array holds
  assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
  assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rdWe && rdAddr != '0) begin
      regs[rdAddr] <= rdData;
    end
  end

endmodule

// ==== logic/intAlu.sv ====
module intAlu (
  input  rvPkg::addr_t     pc,
  input  rvPkg::xlen_t     rs1Data,
  input  rvPkg::xlen_t     rs2Data,
  input  rvPkg::xlen_t     imm,
  input  rvPkg::aluOp_t    aluOp,
  input  rvPkg::opASel_t   opASel,
  input  rvPkg::opBSel_t   opBSel,
  input  rvPkg::branchOp_t branchOp,
  output rvPkg::xlen_t     aluRes,
  output logic             takeBranch,
  output rvPkg::addr_t     target
);

  rvPkg::xlen_t a, b;
  logic [31:0]  word;
  logic         eq, lt;

  always_comb begin
    case (opASel)
      rvPkg::opAPc:   a = pc;
      rvPkg::opAZero: a = '0;
      default:        a = rs1Data;
    endcase
    b = (opBSel == rvPkg::opBImm) ? imm : rs2Data;
  end

  // low half for the w forms
  assign word = (aluOp == rvPkg::aluSubw) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];

  always_comb begin
    case (aluOp)
      rvPkg::aluSub:   aluRes = a - b;
      rvPkg::aluAnd:   aluRes = a & b;
      rvPkg::aluOr:    aluRes = a | b;
      rvPkg::aluXor:   aluRes = a ^ b;
      rvPkg::aluSll:   aluRes = a << b[5:0];
      rvPkg::aluSrl:   aluRes = a >> b[5:0];
      rvPkg::aluSlt:   aluRes = {63'b0, $signed(a) < $signed(b)};
      rvPkg::aluAddw,
      rvPkg::aluSubw:  aluRes = {{32{word[31]}}, word};
      rvPkg::aluPassB: aluRes = b;
      default:         aluRes = a + b;
    endcase
  end

  // branch compare always on the raw registers
  assign eq = (rs1Data == rs2Data);
  assign lt = $signed(rs1Data) < $signed(rs2Data);

  always_comb begin
    case (branchOp)
      rvPkg::brEq:   takeBranch = eq;
      rvPkg::brNe:   takeBranch = !eq;
      rvPkg::brLt:   takeBranch = lt;
      rvPkg::brGe:   takeBranch = !lt;
      rvPkg::brJal,
      rvPkg::brJalr: takeBranch = 1'b1;
      default:       takeBranch = 1'b0;
    endcase
  end

  assign target = (branchOp == rvPkg::brJalr) ? ((rs1Data + imm) & ~64'd1) : pc + imm;

endmodule

// ==== logic/loadStoreUnit.sv ====
module loadStoreUnit #(
  parameter int dmemWords = 128
) (
  input  logic             clk,
  input  logic             step,
  input  rvPkg::xlen_t     aluRes,
  input  rvPkg::xlen_t     storeData,
  input  logic             memRead,
  input  logic             memWrite,
  input  rvPkg::memSize_t  memSize,
  input  logic             loadUnsigned,
  input  rvPkg::wbSel_t    wbSel,
  input  rvPkg::addr_t     pc,
  input  rvPkg::addr_t     hostAddr,
  output rvPkg::xlen_t     rdData,
  output rvPkg::xlen_t     hostData
);

  localparam int dmemAw = $clog2(dmemWords);

  rvPkg::xlen_t     dmem [dmemWords];
  logic [dmemAw-1:0] idx;
  logic [2:0]        byteOff;   // lane offset, aligned to the access size
  rvPkg::byteMask_t  sizeMask;
  rvPkg::byteMask_t  mask;
  rvPkg::xlen_t      wdata;
  rvPkg::xlen_t      lane;
  rvPkg::xlen_t      loadData;

  assign idx = aluRes[3 +: dmemAw];

  always_comb begin
    case (memSize)
      rvPkg::memByte: begin
        byteOff  = aluRes[2:0];
        sizeMask = 8'h01;
      end
      rvPkg::memWord: begin
        byteOff  = {aluRes[2], 2'b00};
        sizeMask = 8'h0f;
      end
      default: begin
        byteOff  = 3'b000;
        sizeMask = 8'hff;
      end
    endcase
  end

  assign mask  = sizeMask << byteOff;
  assign wdata = storeData << {byteOff, 3'b000};

  always_ff @(posedge clk) begin
    if (memWrite && step) begin
      for (int i = 0; i < 8; i++) begin
        if (mask[i]) dmem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  assign lane = dmem[idx] >> {byteOff, 3'b000};

  always_comb begin
    case (memSize)
      rvPkg::memByte: loadData = {{56{lane[7] && !loadUnsigned}}, lane[7:0]};
      rvPkg::memWord: loadData = {{32{lane[31] && !loadUnsigned}}, lane[31:0]};
      default:        loadData = lane;
    endcase
    if (!memRead) loadData = '0;
  end

  always_comb begin
    case (wbSel)
      rvPkg::wbLoad: rdData = loadData;
      rvPkg::wbPc4:  rdData = pc + 64'd4; // link value
      default:       rdData = aluRes;
    endcase
  end

  assign hostData = dmem[hostAddr[3 +: dmemAw]];

endmodule

// ==== logic/coreTop.sv ====
module coreTop #(
  parameter rvPkg::addr_t resetPc = '0,
  parameter int imemWords = 256,
  parameter int dmemWords = 128
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  input  logic                         imemWe,
  input  logic [$clog2(imemWords)-1:0] imemAddr,
  input  rvPkg::inst_t                 imemData,
  input  rvPkg::addr_t                 hostAddr,
  output rvPkg::xlen_t                 hostData,
  output rvPkg::addr_t                 pc,
  output logic                         halted
);

  rvPkg::inst_t     inst;
  logic             step;
  logic             takeBranch;
  rvPkg::addr_t     target;
  logic             isHalt;
  rvPkg::regAddr_t  rs1Addr, rs2Addr, rdAddr;
  rvPkg::xlen_t     imm;
  rvPkg::aluOp_t    aluOp;
  rvPkg::opASel_t   opASel;
  rvPkg::opBSel_t   opBSel;
  rvPkg::branchOp_t branchOp;
  logic             memRead, memWrite, loadUnsigned, rdWe;
  rvPkg::memSize_t  memSize;
  rvPkg::wbSel_t    wbSel;
  rvPkg::xlen_t     rs1Data, rs2Data, rdData, aluRes;

  fetchUnit #(.resetPc(resetPc), .imemWords(imemWords)) fetch (
    .clk, .rst, .run, .imemWe, .imemAddr, .imemData,
    .takeBranch, .target, .isHalt,
    .pc, .inst, .step, .halted
  );

  instDecoder decode (
    .inst, .step,
    .rs1Addr, .rs2Addr, .rdAddr, .imm,
    .aluOp, .opASel, .opBSel, .branchOp,
    .memRead, .memWrite, .memSize, .loadUnsigned,
    .wbSel, .rdWe, .isHalt
  );

  registerFile regs (
    .clk, .rst, .rs1Addr, .rs2Addr, .rdAddr, .rdData, .rdWe,
    .rs1Data, .rs2Data
  );

  intAlu alu (
    .pc, .rs1Data, .rs2Data, .imm, .aluOp, .opASel, .opBSel, .branchOp,
    .aluRes, .takeBranch, .target
  );

  // rs2 doubles as store data
  loadStoreUnit #(.dmemWords(dmemWords)) lsu (
    .clk, .step, .aluRes, .storeData(rs2Data),
    .memRead, .memWrite, .memSize, .loadUnsigned, .wbSel,
    .pc, .hostAddr, .rdData, .hostData
  );

endmodule

// ==== bench/coreTb.sv ====
module coreTb;
  timeunit 1ns;
  timeprecision 100ps;

  // cycles per test for loading, reset, execution and readback
  localparam int budgetCycles = 3 * 200 + 200 + 250 + 100 + 100;

  logic        clk, rst, run, imemWe, halted;
  logic [7:0]  imemAddr;
  logic [31:0] imemData;
  logic [63:0] hostAddr, hostData, pc;

  logic [31:0] prog [$];
  logic [63:0] addrQ [$];
  logic [63:0] expQ [$];
  logic [7:0]  bmem [int];  // byte image of data memory
  int          haltPc;
  integer      seed = 32'hbc128ce8;

  coreTop dut (
    .clk, .rst, .run, .imemWe, .imemAddr, .imemData,
    .hostAddr, .hostData, .pc, .halted
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(budgetCycles * 20 + 2000);
    $display("simulation timed out before halt");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, actual, expected);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [63:0] sx32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] sx12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic int here();
    return prog.size() * 4;
  endfunction

  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  task automatic emitHalt();
    haltPc = here();
    emit(iType(12'd1, 0, 3'd0, 0, 7'h73));  // ebreak
  endtask

  // lui then addiw leaves the value sign-extended from bit 31
  task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(uType(hi[31:12], rd, 7'h37));
    emit(iType(v[11:0], rd, 3'd0, rd, 7'h1b));
  endtask

  // sd rs to the next free slot above base
  task automatic storeResult(input logic [4:0] rs, input logic [11:0] base,
                             input logic [63:0] expected);
    logic [11:0] addr;
    addr = base + 12'(8 * addrQ.size());
    emit(sType(addr, rs, 0, 3'd3));
    addrQ.push_back({52'b0, addr});
    expQ.push_back(expected);
  endtask

  task automatic regOp(input logic [6:0] f7, input logic [2:0] f3, input logic [6:0] op,
                       input logic [63:0] expected);
    emit(rType(f7, 2, 1, f3, 3, op));
    storeResult(3, 12'h000, expected);
  endtask

  task automatic immOp(input logic [11:0] imm, input logic [2:0] f3, input logic [6:0] op,
                       input logic [63:0] expected);
    emit(iType(imm, 1, f3, 3, op));
    storeResult(3, 12'h000, expected);
  endtask

  task automatic loadProgram();
    @(negedge clk);
    run = 1'b0;
    foreach (prog[i]) begin
      imemWe = 1'b1;
      imemAddr = 8'(i);
      imemData = prog[i];
      @(negedge clk);
    end
    imemWe = 1'b0;
  endtask

  task automatic runProgram();
    loadProgram();
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    run = 1'b1;
    do begin
      @(negedge clk);
    end while (!halted);
    check(pc, 64'(haltPc), "pc at halt");
    prog.delete();
  endtask

  task automatic checkResults(input string tag);
    foreach (addrQ[i]) begin
      @(negedge clk);
      hostAddr = addrQ[i];
      @(posedge clk);
      check(hostData, expQ[i], $sformatf("%s, doubleword at %0h", tag, addrQ[i]));
    end
    addrQ.delete();
    expQ.delete();
  endtask

  task automatic testArith(input int round);
    logic [31:0] ra, rb;
    logic [11:0] ri;
    logic [5:0]  sh;
    logic [19:0] ru;
    logic [63:0] a, b, imm, pcv;
    ra = $random(seed);
    rb = $random(seed);
    ri = 12'($random(seed));
    sh = 6'($random(seed));
    ru = 20'($random(seed));
    a = sx32(ra);
    b = sx32(rb);
    imm = sx12(ri);
    loadConst(1, ra);
    loadConst(2, rb);
    regOp(7'h00, 3'd0, 7'h33, a + b);
    regOp(7'h20, 3'd0, 7'h33, a - b);
    regOp(7'h00, 3'd7, 7'h33, a & b);
    regOp(7'h00, 3'd6, 7'h33, a | b);
    regOp(7'h00, 3'd4, 7'h33, a ^ b);
    regOp(7'h00, 3'd1, 7'h33, a << b[5:0]);
    regOp(7'h00, 3'd5, 7'h33, a >> b[5:0]);
    regOp(7'h00, 3'd2, 7'h33, {63'b0, $signed(a) < $signed(b)});
    regOp(7'h00, 3'd0, 7'h3b, sx32(ra + rb));  // addw
    regOp(7'h20, 3'd0, 7'h3b, sx32(ra - rb));  // subw
    immOp(ri, 3'd0, 7'h13, a + imm);
    immOp(ri, 3'd7, 7'h13, a & imm);
    immOp(ri, 3'd6, 7'h13, a | imm);
    immOp(ri, 3'd4, 7'h13, a ^ imm);
    immOp(ri, 3'd2, 7'h13, {63'b0, $signed(a) < $signed(imm)});
    immOp({6'b0, sh}, 3'd1, 7'h13, a << sh);
    immOp({6'b0, sh}, 3'd5, 7'h13, a >> sh);
    immOp(ri, 3'd0, 7'h1b, sx32(ra + imm[31:0]));
    emit(uType(ru, 3, 7'h37));
    storeResult(3, 12'h000, sx32({ru, 12'b0}));
    pcv = 64'(here());
    emit(uType(ru, 3, 7'h17));  // auipc
    storeResult(3, 12'h000, pcv + sx32({ru, 12'b0}));
    emitHalt();
    runProgram();
    checkResults($sformatf("arith round %0d", round));
  endtask

  task automatic storeOp(input logic [2:0] f3, input logic [4:0] rs, input logic [63:0] value,
                         input logic [11:0] addr);
    int n;
    n = 1 << f3;
    emit(sType(addr, rs, 0, f3));
    for (int i = 0; i < n; i++) begin
      bmem[int'(addr) + i] = value[i*8 +: 8];
    end
  endtask

  // load into x7, then park x7 in the result area
  task automatic loadOp(input logic [2:0] f3, input logic [11:0] addr);
    logic [63:0] v;
    int n;
    n = 1 << f3[1:0];
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i*8 +: 8] = bmem[int'(addr) + i];
    end
    if (!f3[2] && v[n*8-1]) begin
      v = v | (~64'd0 << (n * 8));
    end
    emit(iType(addr, 0, f3, 7, 7'h03));
    storeResult(7, 12'h200, v);
  endtask

  task automatic testLoadStore();
    logic [31:0] ra, rb;
    ra = $random(seed) | 32'h80808080;  // every byte negative
    rb = $random(seed) & 32'h7f7f7f7f;
    bmem.delete();
    loadConst(1, ra);
    loadConst(2, rb);
    emit(iType(12'd32, 1, 3'd1, 3, 7'h13));
    emit(iType(12'd32, 2, 3'd1, 4, 7'h13));
    emit(iType(12'd32, 4, 3'd5, 4, 7'h13));    // rb zero-extended
    emit(rType(7'h00, 4, 3, 3'd6, 5, 7'h33));  // x5 = {ra, rb}
    storeOp(3'd3, 5, {ra, rb}, 12'h100);
    storeOp(3'd3, 4, {32'b0, rb}, 12'h108);
    storeOp(3'd2, 2, sx32(rb), 12'h104);
    storeOp(3'd0, 1, sx32(ra), 12'h109);
    storeOp(3'd0, 2, sx32(rb), 12'h10a);
    storeOp(3'd2, 1, sx32(ra), 12'h10c);
    loadOp(3'd0, 12'h109);
    loadOp(3'd4, 12'h109);
    loadOp(3'd0, 12'h10a);
    loadOp(3'd4, 12'h103);
    loadOp(3'd0, 12'h10f);
    loadOp(3'd4, 12'h10d);
    loadOp(3'd2, 12'h10c);
    loadOp(3'd2, 12'h104);
    loadOp(3'd2, 12'h108);
    loadOp(3'd3, 12'h100);
    loadOp(3'd3, 12'h108);
    emitHalt();
    runProgram();
    checkResults("load/store");
  endtask

  task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [31:0] va, input logic [31:0] vb);
    logic taken;
    case (f3)
      3'd0: taken = (va == vb);
      3'd1: taken = (va != vb);
      3'd4: taken = $signed(va) < $signed(vb);
      default: taken = $signed(va) >= $signed(vb);
    endcase
    emit(iType(12'd0, 0, 3'd0, 5, 7'h13));
    emit(bType(13'd8, rs2, rs1, f3));
    emit(iType(12'd7, 0, 3'd0, 5, 7'h13)); // marker skipped when taken
    storeResult(5, 12'h300, taken ? 64'd0 : 64'd7);
  endtask

  task automatic testBranch();
    logic [31:0] neg, pos;
    int n, loopPc;
    neg = $random(seed) | 32'h80000000;
    pos = $random(seed) & 32'h7fffffff;
    n = 3 + ($random(seed) & 32'h7);
    loadConst(3, neg);
    loadConst(4, pos);
    emit(iType(12'(n), 0, 3'd0, 1, 7'h13));
    emit(iType(12'd0, 0, 3'd0, 2, 7'h13));    // counter from zero
    loopPc = here();
    emit(iType(12'd1, 2, 3'd0, 2, 7'h13));    // counter up
    emit(iType(12'hfff, 1, 3'd0, 1, 7'h13));  // count down
    emit(bType(13'(loopPc - here()), 0, 1, 3'd1));
    storeResult(2, 12'h300, 64'(n));
    branchCase(3'd4, 3, 4, neg, pos);
    branchCase(3'd4, 4, 3, pos, neg);
    branchCase(3'd4, 3, 3, neg, neg);
    branchCase(3'd5, 3, 4, neg, pos);
    branchCase(3'd5, 4, 3, pos, neg);
    branchCase(3'd5, 3, 3, neg, neg);
    branchCase(3'd0, 3, 3, neg, neg);
    branchCase(3'd0, 3, 4, neg, pos);
    branchCase(3'd1, 3, 4, neg, pos);
    emitHalt();
    runProgram();
    checkResults("branch");
  endtask

  task automatic testJump();
    int jalPc, jalrPc;
    emit(iType(12'd0, 0, 3'd0, 5, 7'h13));  // markers start clear
    emit(iType(12'd0, 0, 3'd0, 8, 7'h13));
    jalPc = here();
    emit(jType(21'd8, 1));
    emit(iType(12'd99, 0, 3'd0, 5, 7'h13));  // skipped
    storeResult(1, 12'h400, 64'(jalPc + 4));
    storeResult(5, 12'h400, 64'd0);
    jalrPc = here() + 4;
    emit(iType(12'(jalrPc + 8), 0, 3'd0, 6, 7'h13));
    emit(iType(12'd1, 6, 3'd0, 7, 7'h67));  // jalr x7, 1(x6) drops bit 0 of the target
    emit(iType(12'd55, 0, 3'd0, 8, 7'h13));  // skipped
    storeResult(7, 12'h400, 64'(jalrPc + 4));
    storeResult(8, 12'h400, 64'd0);
    emitHalt();
    runProgram();
    checkResults("jump");
  endtask

  task automatic testHalt();
    emit(iType(12'd123, 0, 3'd0, 0, 7'h13));
    emit(uType(20'h12345, 0, 7'h37));
    storeResult(0, 12'h500, 64'd0);
    emit(iType(12'd5, 0, 3'd0, 1, 7'h13));
    storeResult(1, 12'h500, 64'd5);
    storeResult(0, 12'h500, 64'd0);
    emitHalt();
    emit(sType(12'h510, 1, 0, 3'd3));  // never runs past the ebreak
    runProgram();
    repeat (5) @(negedge clk);
    check({63'b0, halted}, 64'd1, "halted holds");
    check(pc, 64'(haltPc), "pc holds at ebreak");
    checkResults("halt and x0");
  endtask

  initial begin
    rst = 1'b1;
    run = 1'b0;
    imemWe = 1'b0;
    imemAddr = '0;
    imemData = '0;
    hostAddr = '0;
    for (int r = 0; r < 3; r++) begin
      testArith(r);
    end
    testLoadStore();
    testBranch();
    testJump();
    testHalt();
    $display("sim passed");
    $finish;
  end

endmodule

// ==== all.f ====
logic/rvPkg.sv
logic/fetchUnit.sv
logic/instDecoder.sv
logic/registerFile.sv
logic/intAlu.sv
logic/loadStoreUnit.sv
logic/coreTop.sv
bench/coreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module coreTb -o coreSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/coreSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass message not found"
exit 1
